// ==== Bender.yml ====
package:
  name: fpu_mds

sources:
  - hw/fpu_pkg.sv
  - hw/fpu_classify.sv
  - hw/fpu_exp_prenorm.sv
  - hw/fpu_mul.sv
  - hw/fpu_div.sv
  - hw/fpu_sqrt.sv
  - hw/fpu_round_norm.sv
  - hw/fpu_mds_ctrl.sv
  - hw/fpu_mds_top.sv
  - target: test
    files:
      - sim/fpu_mds_tb.sv

// ==== build.f ====
hw/fpu_pkg.sv
hw/fpu_classify.sv
hw/fpu_exp_prenorm.sv
hw/fpu_mul.sv
hw/fpu_div.sv
hw/fpu_sqrt.sv
hw/fpu_round_norm.sv
hw/fpu_mds_ctrl.sv
hw/fpu_mds_top.sv
sim/fpu_mds_tb.sv

// ==== hw/fpu_classify.sv ====
`timescale 1ns/1ps

module fpu_classify (
    input  logic [31:0]          word,
    output fpu_pkg::fp_operand_t opnd
);

    logic exp_zero;
    logic exp_ones;
    logic frac_zero;

    assign exp_zero  = word[30:23] == 8'h00;
    assign exp_ones  = word[30:23] == 8'hff;
    assign frac_zero = word[22:0] == 23'h0;

    always_comb begin
        opnd.sign = word[31];
        opnd.exp  = word[30:23];
        // Subnormals flush to zero, hidden bit cleared
        opnd.sig  = exp_zero ? 24'h0 : {1'b1, word[22:0]};

        opnd.is_zero = exp_zero;
        opnd.is_inf  = exp_ones & frac_zero;
        opnd.is_nan  = exp_ones & ~frac_zero;
        // Quiet bit is the top fraction bit
        opnd.is_snan = exp_ones & ~frac_zero & ~word[22];
    end

endmodule

// ==== hw/fpu_div.sv ====
`timescale 1ns/1ps

module fpu_div (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  fpu_pkg::fp_operand_t  a,
    input  fpu_pkg::fp_operand_t  b,
    input  logic [8:0]            pre_exp,
    input  logic                  exp_uf,
    output logic                  done,
    output fpu_pkg::unit_result_t res
);

    logic        busy;
    logic        load;
    logic [4:0]  cnt;
    logic [25:0] rem;
    logic [25:0] quo;
    logic [9:0]  exp_in;
    logic [9:0]  exp_q;
    logic [26:0] diff;

    assign load   = start & ~busy & ~done;
    assign exp_in = exp_uf ? 10'h300 : {1'b0, pre_exp};
    assign diff   = {1'b0, rem} - {3'b000, b.sig};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (load) begin
            busy <= 1'b1;
            cnt  <= 5'd26;
        end else if (busy) begin
            cnt <= cnt - 5'd1;
            if (cnt == 5'd1) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (done && !start) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quo <= '0;
            // Smaller dividend is doubled so the first quotient bit is set
            if (a.sig < b.sig) begin
                rem   <= {1'b0, a.sig, 1'b0};
                exp_q <= exp_in - 10'd1;
            end else begin
                rem   <= {2'b00, a.sig};
                exp_q <= exp_in;
            end
        end else if (busy) begin
            rem <= diff[26] ? {rem[24:0], 1'b0} : {diff[24:0], 1'b0};
            quo <= {quo[24:0], ~diff[26]};
        end
    end

    assign res.exp = exp_q;
    assign res.sig = {quo, |rem};

endmodule

// ==== hw/fpu_exp_prenorm.sv ====
`timescale 1ns/1ps

module fpu_exp_prenorm (
    input  fpu_pkg::mds_op_e     op,
    input  fpu_pkg::fp_operand_t a,
    input  fpu_pkg::fp_operand_t b,
    output logic [8:0]           pre_exp,
    output logic                 exp_uf
);
    import fpu_pkg::*;

    logic [9:0]        sum;
    logic [9:0]        num;
    logic signed [8:0] sq_unb;
    logic signed [8:0] sq_half;

    assign sum     = {2'b00, a.exp} + {2'b00, b.exp};
    assign num     = {2'b00, a.exp} + 10'(BIAS);
    assign sq_unb  = $signed({1'b0, a.exp}) - 9'(BIAS);
    assign sq_half = sq_unb >>> 1;

    always_comb begin
        case (op)
            DIV: begin
                exp_uf  = num <= {2'b00, b.exp};
                pre_exp = 9'(num - {2'b00, b.exp});
            end
            SQRT: begin
                // Halved exponent on top, odd flag in bit 0
                exp_uf  = 1'b0;
                pre_exp = {sq_half[7:0] + 8'(BIAS), sq_unb[0]};
            end
            default: begin
                exp_uf  = sum <= 10'(BIAS);
                pre_exp = 9'(sum - 10'(BIAS));
            end
        endcase
    end

endmodule

// ==== hw/fpu_mds_ctrl.sv ====
`timescale 1ns/1ps

module fpu_mds_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  fpu_pkg::mds_req_t     rq,
    input  fpu_pkg::fp_operand_t  a,
    input  fpu_pkg::fp_operand_t  b,
    input  fpu_pkg::unit_result_t mul_res,
    input  logic                  div_done,
    input  fpu_pkg::unit_result_t div_res,
    input  logic                  sqrt_done,
    input  fpu_pkg::unit_result_t sqrt_res,
    input  logic [31:0]           rnd_word,
    input  fpu_pkg::fp_flags_t    rnd_flags,
    output logic                  div_start,
    output logic                  sqrt_start,
    output fpu_pkg::unit_result_t sel_res,
    output logic                  sign,
    output logic                  ack,
    output fpu_pkg::mds_resp_t    resp
);
    import fpu_pkg::*;

    typedef enum logic [2:0] {IDLE, MUL_WAIT, ITER, WRITE, ACK, DROP} state_e;

    state_e      state;
    logic        fast;
    logic        b_used;
    logic        unit_done;
    logic [31:0] inf_word;
    logic [31:0] zero_word;
    logic [31:0] fast_word;
    fp_flags_t   fast_flags;

    assign sign      = (rq.op == SQRT) ? a.sign : a.sign ^ b.sign;
    assign b_used    = rq.op != SQRT;
    assign unit_done = (rq.op == SQRT) ? sqrt_done : div_done;
    assign inf_word  = {sign, 8'hff, 23'h0};
    assign zero_word = {sign, 31'h0};

    assign div_start  = (state == ITER) && (rq.op == DIV);
    assign sqrt_start = (state == ITER) && (rq.op == SQRT);
    assign ack        = state == ACK;

    always_comb begin
        case (rq.op)
            DIV:     sel_res = div_res;
            SQRT:    sel_res = sqrt_res;
            default: sel_res = mul_res;
        endcase
    end

    // Special operands bypass the units
    always_comb begin
        fast       = 1'b1;
        fast_word  = QNAN;
        fast_flags = '0;
        if (a.is_nan || (b_used && b.is_nan)) begin
            fast_flags.invalid = a.is_snan || (b_used && b.is_snan);
        end else begin
            case (rq.op)
                SQRT: begin
                    if (a.is_zero) fast_word = zero_word;
                    else if (a.sign) fast_flags.invalid = 1'b1;
                    else if (a.is_inf) fast_word = inf_word;
                    else fast = 1'b0;
                end
                DIV: begin
                    if ((a.is_zero && b.is_zero) || (a.is_inf && b.is_inf)) begin
                        fast_flags.invalid = 1'b1;
                    end else if (a.is_inf) begin
                        fast_word = inf_word;
                    end else if (b.is_zero) begin
                        fast_word              = inf_word;
                        fast_flags.div_by_zero = 1'b1;
                    end else if (a.is_zero || b.is_inf) begin
                        fast_word = zero_word;
                    end else begin
                        fast = 1'b0;
                    end
                end
                default: begin
                    if ((a.is_inf && b.is_zero) || (a.is_zero && b.is_inf)) begin
                        fast_flags.invalid = 1'b1;
                    end else if (a.is_inf || b.is_inf) begin
                        fast_word = inf_word;
                    end else if (a.is_zero || b.is_zero) begin
                        fast_word = zero_word;
                    end else begin
                        fast = 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
            resp  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        if (fast) begin
                            resp  <= {fast_word, fast_flags};
                            state <= ACK;
                        end else if (rq.op == DIV || rq.op == SQRT) begin
                            state <= ITER;
                        end else begin
                            state <= MUL_WAIT;
                        end
                    end
                end
                MUL_WAIT: begin
                    resp  <= {rnd_word, rnd_flags};
                    state <= ACK;
                end
                ITER: begin
                    if (unit_done) state <= WRITE;
                end
                WRITE: begin
                    resp  <= {rnd_word, rnd_flags};
                    state <= ACK;
                end
                ACK: begin
                    if (!req) state <= DROP;
                end
                DROP: begin
                    // Unit handshake must be closed before the next request
                    if (!div_done && !sqrt_done) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== hw/fpu_mds_top.sv ====
`timescale 1ns/1ps

module fpu_mds_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  fpu_pkg::mds_req_t  rq,
    output logic               ack,
    output fpu_pkg::mds_resp_t resp
);
    import fpu_pkg::*;

    fp_operand_t  opnd_a;
    fp_operand_t  opnd_b;
    logic [8:0]   pre_exp;
    logic         exp_uf;
    unit_result_t mul_res;
    unit_result_t div_res;
    unit_result_t sqrt_res;
    unit_result_t sel_res;
    logic         div_start;
    logic         div_done;
    logic         sqrt_start;
    logic         sqrt_done;
    logic         sign;
    logic [31:0]  rnd_word;
    fp_flags_t    rnd_flags;

    fpu_classify u_cls_a (.word(rq.a), .opnd(opnd_a));
    fpu_classify u_cls_b (.word(rq.b), .opnd(opnd_b));

    fpu_exp_prenorm u_prenorm (
        .op(rq.op), .a(opnd_a), .b(opnd_b),
        .pre_exp(pre_exp), .exp_uf(exp_uf)
    );

    fpu_mul u_mul (
        .clk(clk), .reset(reset), .a(opnd_a), .b(opnd_b),
        .pre_exp(pre_exp), .exp_uf(exp_uf), .res(mul_res)
    );

    fpu_div u_div (
        .clk(clk), .reset(reset), .start(div_start), .a(opnd_a), .b(opnd_b),
        .pre_exp(pre_exp), .exp_uf(exp_uf), .done(div_done), .res(div_res)
    );

    fpu_sqrt u_sqrt (
        .clk(clk), .reset(reset), .start(sqrt_start), .a(opnd_a),
        .pre_exp(pre_exp), .done(sqrt_done), .res(sqrt_res)
    );

    fpu_round_norm u_round (
        .sign(sign), .rm(rq.rm), .res(sel_res),
        .word(rnd_word), .flags(rnd_flags)
    );

    fpu_mds_ctrl u_ctrl (
        .clk(clk), .reset(reset), .req(req), .rq(rq),
        .a(opnd_a), .b(opnd_b), .mul_res(mul_res),
        .div_done(div_done), .div_res(div_res),
        .sqrt_done(sqrt_done), .sqrt_res(sqrt_res),
        .rnd_word(rnd_word), .rnd_flags(rnd_flags),
        .div_start(div_start), .sqrt_start(sqrt_start),
        .sel_res(sel_res), .sign(sign), .ack(ack), .resp(resp)
    );

endmodule

// ==== hw/fpu_mul.sv ====
`timescale 1ns/1ps

module fpu_mul (
    input  logic                  clk,
    input  logic                  reset,
    input  fpu_pkg::fp_operand_t  a,
    input  fpu_pkg::fp_operand_t  b,
    input  logic [8:0]            pre_exp,
    input  logic                  exp_uf,
    output fpu_pkg::unit_result_t res
);

    logic [47:0] prod;
    logic [9:0]  exp_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prod  <= '0;
            exp_q <= '0;
        end else begin
            prod  <= a.sig * b.sig;
            // Early underflow parks the exponent far below the normal range
            exp_q <= exp_uf ? 10'h300 : {1'b0, pre_exp};
        end
    end

    // Product lies in [1,4)
    always_comb begin
        if (prod[47]) begin
            res.exp = exp_q + 10'd1;
            res.sig = {prod[47:22], |prod[21:0]};
        end else begin
            res.exp = exp_q;
            res.sig = {prod[46:21], |prod[20:0]};
        end
    end

endmodule

// ==== hw/fpu_pkg.sv ====
package fpu_pkg;

    localparam int BIAS = 127;
    localparam logic [31:0] QNAN = 32'h7fc0_0000;

    typedef enum logic [1:0] {
        MUL  = 2'd0,
        DIV  = 2'd1,
        SQRT = 2'd2
    } mds_op_e;

    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } round_mode_e;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [23:0] sig;
        logic        is_zero;
        logic        is_inf;
        logic        is_nan;
        logic        is_snan;
    } fp_operand_t;

    typedef struct packed {
        logic invalid;
        logic div_by_zero;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    typedef struct packed {
        mds_op_e     op;
        round_mode_e rm;
        logic [31:0] a;
        logic [31:0] b;
    } mds_req_t;

    typedef struct packed {
        logic [31:0] result;
        fp_flags_t   flags;
    } mds_resp_t;

    // Significand is hidden bit, fraction, guard, round, sticky
    typedef struct packed {
        logic signed [9:0] exp;
        logic [26:0]       sig;
    } unit_result_t;

endpackage

// ==== hw/fpu_round_norm.sv ====
`timescale 1ns/1ps

module fpu_round_norm (
    input  logic                  sign,
    input  fpu_pkg::round_mode_e  rm,
    input  fpu_pkg::unit_result_t res,
    output logic [31:0]           word,
    output fpu_pkg::fp_flags_t    flags
);
    import fpu_pkg::*;

    logic              lsb;
    logic              guard;
    logic              rest;
    logic              inexact;
    logic              inc;
    logic              to_max;
    logic [24:0]       mant;
    logic signed [9:0] exp_r;

    assign lsb     = res.sig[3];
    assign guard   = res.sig[2];
    assign rest    = res.sig[1] | res.sig[0];
    assign inexact = guard | rest;

    always_comb begin
        case (rm)
            RTZ:     inc = 1'b0;
            RDN:     inc = sign & inexact;
            RUP:     inc = ~sign & inexact;
            RMM:     inc = guard;
            default: inc = guard & (rest | lsb);
        endcase
    end

    // Carry out of the significand bumps the exponent
    assign mant  = {1'b0, res.sig[26:3]} + 25'(inc);
    assign exp_r = $signed(res.exp) + $signed({9'd0, mant[24]});

    // Modes that never round away from zero for this sign
    assign to_max = (rm == RTZ) | ((rm == RDN) & ~sign) | ((rm == RUP) & sign);

    always_comb begin
        flags = '0;
        if (exp_r > 10'sd254) begin
            word           = to_max ? {sign, 8'hfe, 23'h7f_ffff} : {sign, 8'hff, 23'h0};
            flags.overflow = 1'b1;
            flags.inexact  = 1'b1;
        end else if (exp_r < 10'sd1) begin
            word            = {sign, 31'h0};
            flags.underflow = 1'b1;
            flags.inexact   = 1'b1;
        end else begin
            word          = {sign, exp_r[7:0], mant[24] ? mant[23:1] : mant[22:0]};
            flags.inexact = inexact;
        end
    end

endmodule

// ==== hw/fpu_sqrt.sv ====
`timescale 1ns/1ps

module fpu_sqrt (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  fpu_pkg::fp_operand_t  a,
    input  logic [8:0]            pre_exp,
    output logic                  done,
    output fpu_pkg::unit_result_t res
);

    logic               busy;
    logic               load;
    logic [4:0]         cnt;
    logic [51:0]        rad;
    logic [25:0]        root;
    logic [7:0]         exp_q;
    logic signed [31:0] rem;
    logic signed [31:0] rem_sh;
    logic signed [31:0] rem_nx;
    logic signed [31:0] rem_fix;

    assign load = start & ~busy & ~done;

    // Non-restoring step, two radicand bits per root bit
    assign rem_sh  = {rem[29:0], rad[51:50]};
    assign rem_nx  = rem[31] ? rem_sh + {4'b0, root, 2'b11} : rem_sh - {4'b0, root, 2'b01};
    assign rem_fix = rem[31] ? rem + {5'b0, root, 1'b1} : rem;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (load) begin
            busy <= 1'b1;
            cnt  <= 5'd26;
        end else if (busy) begin
            cnt <= cnt - 5'd1;
            if (cnt == 5'd1) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (done && !start) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            // Odd exponent moves one place into the significand
            rad   <= pre_exp[0] ? {a.sig, 28'b0} : {1'b0, a.sig, 27'b0};
            rem   <= '0;
            root  <= '0;
            exp_q <= pre_exp[8:1];
        end else if (busy) begin
            rad  <= {rad[49:0], 2'b00};
            rem  <= rem_nx;
            root <= {root[24:0], ~rem_nx[31]};
        end
    end

    assign res.exp = {2'b00, exp_q};
    assign res.sig = {root, |rem_fix};

endmodule

// ==== sim/fpu_mds_tb.sv ====
`timescale 1ns/1ps

module fpu_mds_tb;
    import fpu_pkg::*;

    localparam int TIMEOUT = 200;

    logic      clk;
    logic      reset;
    logic      req;
    mds_req_t  rq;
    logic      ack;
    mds_resp_t resp;
    integer    seed;

    fpu_mds_top uut (.clk(clk), .reset(reset), .req(req), .rq(rq), .ack(ack), .resp(resp));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %0h expected %0h", name, got, exp));
        end
    endtask

    // Flag bits in the order invalid, div_by_zero, overflow, underflow, inexact
    function automatic logic [4:0] flags_of(input logic inv, input logic dz, input logic of,
                                            input logic uf, input logic nx);
        return {inv, dz, of, uf, nx};
    endfunction

    // Binary32 word for s * m * 2^e, m a nonzero integer below 2^24
    function automatic logic [31:0] make_fp(input logic s, input logic [31:0] m, input int e);
        int          p;
        int          i;
        logic [31:0] norm;
        p = 0;
        for (i = 0; i < 32; i++) begin
            if (m[i]) p = i;
        end
        norm = m << (23 - p);
        return {s, 8'(e + p + BIAS), norm[22:0]};
    endfunction

    task automatic start_op(input mds_op_e op, input round_mode_e rm,
                            input logic [31:0] a, input logic [31:0] b);
        int cnt;
        @(negedge clk);
        rq.op = op;
        rq.rm = rm;
        rq.a  = a;
        rq.b  = b;
        req   = 1'b1;
        cnt   = 0;
        while (!ack && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!ack) fail_run("Timeout: ack never rose after req");
    endtask

    task automatic end_op;
        int cnt;
        req = 1'b0;
        cnt = 0;
        while (ack && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack) fail_run("Timeout: ack stayed high after req dropped");
    endtask

    task automatic do_op(input mds_op_e op, input round_mode_e rm, input logic [31:0] a,
                         input logic [31:0] b, output mds_resp_t r);
        start_op(op, rm, a, b);
        r = resp;
        end_op();
    endtask

    task automatic run_check(input string name, input mds_op_e op, input round_mode_e rm,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] exp_word, input logic [4:0] exp_flags);
        mds_resp_t r;
        do_op(op, rm, a, b, r);
        check($sformatf("%s result", name), r.result, exp_word);
        check($sformatf("%s flags", name), r.flags, exp_flags);
    endtask

    task automatic test_mul_exact;
        logic        sa;
        logic        sb;
        logic [31:0] ma;
        logic [31:0] mb;
        int          ea;
        int          eb;
        int          i;
        run_check("mul 3*5", MUL, RNE, make_fp(0, 3, 0), make_fp(0, 5, 0),
                  make_fp(0, 15, 0), 5'b0);
        run_check("mul -7*0.5", MUL, RTZ, make_fp(1, 7, 0), make_fp(0, 1, -1),
                  make_fp(1, 7, -1), 5'b0);
        for (i = 0; i < 16; i++) begin
            sa = $random(seed) & 1;
            sb = $random(seed) & 1;
            ma = ($random(seed) & 32'hfff) | 32'h1;
            mb = ($random(seed) & 32'hfff) | 32'h1;
            ea = $random(seed) % 20;
            eb = $random(seed) % 20;
            // Products stay below 2^24, so every mode gives the same word
            run_check($sformatf("mul rand %0d", i), MUL, round_mode_e'(i % 5),
                      make_fp(sa, ma, ea), make_fp(sb, mb, eb),
                      make_fp(sa ^ sb, ma * mb, ea + eb), 5'b0);
        end
    endtask

    task automatic test_div_round;
        logic [4:0] nx;
        nx = flags_of(0, 0, 0, 0, 1);
        run_check("div 6/3", DIV, RNE, 32'h40c0_0000, 32'h4040_0000, 32'h4000_0000, 5'b0);
        run_check("div 1/4", DIV, RNE, 32'h3f80_0000, 32'h4080_0000, 32'h3e80_0000, 5'b0);
        run_check("div 1/3 rne", DIV, RNE, 32'h3f80_0000, 32'h4040_0000, 32'h3eaa_aaab, nx);
        run_check("div 1/3 rup", DIV, RUP, 32'h3f80_0000, 32'h4040_0000, 32'h3eaa_aaab, nx);
        run_check("div 1/3 rmm", DIV, RMM, 32'h3f80_0000, 32'h4040_0000, 32'h3eaa_aaab, nx);
        run_check("div 1/3 rtz", DIV, RTZ, 32'h3f80_0000, 32'h4040_0000, 32'h3eaa_aaaa, nx);
        run_check("div 1/3 rdn", DIV, RDN, 32'h3f80_0000, 32'h4040_0000, 32'h3eaa_aaaa, nx);
        // Negative quotient, directed modes trade places
        run_check("div -1/3 rup", DIV, RUP, 32'hbf80_0000, 32'h4040_0000, 32'hbeaa_aaaa, nx);
        run_check("div -1/3 rdn", DIV, RDN, 32'hbf80_0000, 32'h4040_0000, 32'hbeaa_aaab, nx);
    endtask

    task automatic test_sqrt;
        logic [4:0] nx;
        nx = flags_of(0, 0, 0, 0, 1);
        run_check("sqrt 4", SQRT, RNE, 32'h4080_0000, 32'h0, 32'h4000_0000, 5'b0);
        run_check("sqrt 9", SQRT, RNE, 32'h4110_0000, 32'h0, 32'h4040_0000, 5'b0);
        run_check("sqrt 2.25", SQRT, RNE, 32'h4010_0000, 32'h0, 32'h3fc0_0000, 5'b0);
        run_check("sqrt 2 rne", SQRT, RNE, 32'h4000_0000, 32'h0, 32'h3fb5_04f3, nx);
        run_check("sqrt 2 rtz", SQRT, RTZ, 32'h4000_0000, 32'h0, 32'h3fb5_04f3, nx);
        run_check("sqrt 2 rdn", SQRT, RDN, 32'h4000_0000, 32'h0, 32'h3fb5_04f3, nx);
        run_check("sqrt 2 rup", SQRT, RUP, 32'h4000_0000, 32'h0, 32'h3fb5_04f4, nx);
    endtask

    task automatic test_special;
        logic [4:0] inv;
        inv = flags_of(1, 0, 0, 0, 0);
        run_check("qnan", MUL, RNE, 32'h7fc0_0000, 32'h3f80_0000, QNAN, 5'b0);
        run_check("snan", MUL, RNE, 32'h7f80_0001, 32'h3f80_0000, QNAN, inv);
        run_check("inf*0", MUL, RNE, 32'h7f80_0000, 32'h0000_0000, QNAN, inv);
        run_check("5/0", DIV, RNE, 32'h40a0_0000, 32'h0000_0000, 32'h7f80_0000,
                  flags_of(0, 1, 0, 0, 0));
        run_check("sqrt -4", SQRT, RNE, 32'hc080_0000, 32'h0, QNAN, inv);
        run_check("sqrt -0", SQRT, RNE, 32'h8000_0000, 32'h0, 32'h8000_0000, 5'b0);
    endtask

    task automatic test_range;
        run_check("ovf rne", MUL, RNE, make_fp(0, 1, 100), make_fp(0, 1, 100),
                  32'h7f80_0000, flags_of(0, 0, 1, 0, 1));
        run_check("ovf rtz", MUL, RTZ, make_fp(0, 1, 100), make_fp(0, 1, 100),
                  32'h7f7f_ffff, flags_of(0, 0, 1, 0, 1));
        run_check("unf", MUL, RNE, make_fp(0, 1, -100), make_fp(0, 1, -100),
                  32'h0000_0000, flags_of(0, 0, 0, 1, 1));
    endtask

    task automatic test_handshake;
        mds_resp_t held;
        int        i;
        start_op(MUL, RNE, 32'h4040_0000, 32'h4000_0000);
        held = resp;
        check("hold result", held.result, 32'h40c0_0000);
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            check("hold ack", ack, 1'b1);
            check("hold resp", resp, held);
        end
        end_op();
        // Next request goes out as soon as ack has fallen
        run_check("b2b mul", MUL, RNE, 32'h4000_0000, 32'h4040_0000, 32'h40c0_0000, 5'b0);
        run_check("b2b sqrt", SQRT, RNE, 32'h4110_0000, 32'h0, 32'h4040_0000, 5'b0);
        run_check("b2b div", DIV, RNE, 32'h3f80_0000, 32'h4080_0000, 32'h3e80_0000, 5'b0);
    endtask

    initial begin
        seed  = 32'h9148_594a;
        reset = 1'b0;
        req   = 1'b0;
        rq    = '0;
        repeat (3) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        check("reset ack", ack, 1'b0);
        check("reset resp", resp, '0);
        test_mul_exact();
        test_div_round();
        test_sqrt();
        test_special();
        test_range();
        test_handshake();
        $display("All checks passed");
        $finish;
    end

endmodule
